// File: Makefile
TOP       ?= control_unit_tb
SEED      ?= 28208
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
ERR_LIMIT ?= 100

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -j 0 --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f verilog.f
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) \
		+verilator+error+limit+$(ERR_LIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/control_encoder.sv
`include "cu_macros.svh"

module control_encoder (
  input  cu_pkg::seq_state_e       state,
  input  logic [`STEP_WIDTH-1:0]   step,
  input  cu_pkg::op_class_e        op_class,
  input  cu_pkg::addr_mode_e       addr_mode,
  input  cu_pkg::alu_op_e          alu_op_dec,
  input  cu_pkg::reg_e             reg_sel,
  input  logic [`OPCODE_WIDTH-1:0] opcode,
  input  logic [`FLAG_COUNT-1:0]   flags,
  output cu_pkg::ctrl_word_t       ctrl,
  output cu_pkg::alu_op_e          alu_op,
  output cu_pkg::data_src_e        data_src,
  output cu_pkg::addr_src_e        addr_src,
  output logic                     halted
);

  cu_pkg::flag_e br_flag;
  logic          br_taken;

  // bits 7:6 pick the flag, bit 5 is the value that takes the branch
  assign br_flag  = cu_pkg::flag_e'(opcode[7:6]);
  assign br_taken = (flags[br_flag] == opcode[5]);

  always_comb begin
    ctrl     = '0;
    alu_op   = cu_pkg::alu_add;
    data_src = cu_pkg::src_data_in;
    addr_src = cu_pkg::addr_pc;
    halted   = 1'b0;
    case (state)
      cu_pkg::st_fetch: begin
        ctrl.load_inst_reg = 1'b1;
        ctrl.inc_pc        = 1'b1;
      end
      cu_pkg::st_decode: begin
        if (addr_mode == cu_pkg::mode_abs) begin
          ctrl.inc_pc        = 1'b1;
          ctrl.load_addr_low = 1'b1;
        end
      end
      cu_pkg::st_mem1: begin
        ctrl.inc_pc         = 1'b1;
        ctrl.load_addr_high = 1'b1;
      end
      cu_pkg::st_exec: begin
        if (addr_mode == cu_pkg::mode_abs) addr_src = cu_pkg::addr_reg;
        // step past the operand byte
        if (addr_mode == cu_pkg::mode_imm && step == '0) ctrl.inc_pc = 1'b1;
        case (op_class)
          cu_pkg::cls_arith, cu_pkg::cls_logic, cu_pkg::cls_compare: begin
            alu_op = alu_op_dec;
            case (step)
              `STEP_WIDTH'(0): ctrl.load_input_b = 1'b1;    // operand from memory
              `STEP_WIDTH'(1): begin
                data_src          = cu_pkg::src_reg_a;
                ctrl.load_input_a = 1'b1;
              end
              default: begin
                data_src      = cu_pkg::src_alu_result;
                ctrl.update_n = 1'b1;
                ctrl.update_z = 1'b1;
                ctrl.update_c = (op_class != cu_pkg::cls_logic);
                ctrl.update_v = (op_class == cu_pkg::cls_arith);
                ctrl.load_a   = (op_class != cu_pkg::cls_compare);
              end
            endcase
          end
          cu_pkg::cls_load: begin
            ctrl.load_a   = (reg_sel == cu_pkg::sel_a);
            ctrl.load_x   = (reg_sel == cu_pkg::sel_x);
            ctrl.load_y   = (reg_sel == cu_pkg::sel_y);
            ctrl.update_n = 1'b1;
            ctrl.update_z = 1'b1;
          end
          cu_pkg::cls_store: begin
            ctrl.write = 1'b1;
            case (reg_sel)
              cu_pkg::sel_x: data_src = cu_pkg::src_reg_x;
              cu_pkg::sel_y: data_src = cu_pkg::src_reg_y;
              default:       data_src = cu_pkg::src_reg_a;
            endcase
          end
          cu_pkg::cls_inx: begin
            if (step == '0) begin
              data_src           = cu_pkg::src_reg_x;
              ctrl.load_input_b  = 1'b1;
              ctrl.reset_input_a = 1'b1;    // zeroed input a plus carry gives x + 1
            end else begin
              data_src      = cu_pkg::src_alu_result;
              ctrl.load_x   = 1'b1;
              ctrl.update_n = 1'b1;
              ctrl.update_z = 1'b1;
            end
          end
          cu_pkg::cls_jmp:    ctrl.load_pc = 1'b1;
          cu_pkg::cls_branch: ctrl.load_pc = br_taken;
          cu_pkg::cls_clc:    ctrl.clear_c = 1'b1;
          cu_pkg::cls_sec:    ctrl.set_c   = 1'b1;
          default: ;
        endcase
      end
      cu_pkg::st_halted: halted = 1'b1;
      default: ;
    endcase
  end

endmodule

// File: rtl/control_unit.sv
`include "cu_macros.svh"

module control_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`OPCODE_WIDTH-1:0] opcode,
  input  logic [`FLAG_COUNT-1:0]   flags,
  output cu_pkg::ctrl_word_t       ctrl,
  output cu_pkg::alu_op_e          alu_op,
  output cu_pkg::data_src_e        data_src,
  output cu_pkg::addr_src_e        addr_src,
  output logic                     halted
);

  cu_pkg::op_class_e       op_class;
  cu_pkg::addr_mode_e      addr_mode;
  cu_pkg::alu_op_e         alu_op_dec;
  cu_pkg::reg_e            reg_sel;
  logic                    valid;
  cu_pkg::seq_state_e      state;
  logic [`STEP_WIDTH-1:0]  step;

  opcode_decoder decoder0 (
    .opcode    (opcode),
    .op_class  (op_class),
    .addr_mode (addr_mode),
    .alu_op    (alu_op_dec),
    .reg_sel   (reg_sel),
    .valid     (valid)
  );

  instr_sequencer sequencer0 (
    .clk       (clk),
    .reset     (reset),
    .op_class  (op_class),
    .addr_mode (addr_mode),
    .valid     (valid),
    .state     (state),
    .step      (step)
  );

  control_encoder encoder0 (
    .state      (state),
    .step       (step),
    .op_class   (op_class),
    .addr_mode  (addr_mode),
    .alu_op_dec (alu_op_dec),
    .reg_sel    (reg_sel),
    .opcode     (opcode),
    .flags      (flags),
    .ctrl       (ctrl),
    .alu_op     (alu_op),
    .data_src   (data_src),
    .addr_src   (addr_src),
    .halted     (halted)
  );

endmodule

// File: rtl/cu_macros.svh
`ifndef CU_MACROS_SVH
`define CU_MACROS_SVH

// opcode byte as held in the instruction register
`define OPCODE_WIDTH 8

// status flags N, V, C, Z
`define FLAG_COUNT 4

// longest execute sequence is three steps
`define STEP_WIDTH 2

`endif

// File: rtl/cu_pkg.sv
`include "cu_macros.svh"

package cu_pkg;

  // index order matches opcode bits 7:6 of the branches
  typedef enum logic [1:0] {flag_n = 2'd0, flag_v = 2'd1, flag_c = 2'd2, flag_z = 2'd3} flag_e;

  typedef enum logic [3:0] {
    cls_load, cls_store, cls_arith, cls_logic, cls_compare, cls_inx,
    cls_clc, cls_sec, cls_jmp, cls_branch, cls_nop
  } op_class_e;

  typedef enum logic [1:0] {mode_imm, mode_abs, mode_impl} addr_mode_e;
  typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor} alu_op_e;
  typedef enum logic [1:0] {sel_a, sel_x, sel_y} reg_e;
  typedef enum logic [2:0] {st_fetch, st_decode, st_mem1, st_exec, st_halted} seq_state_e;

  typedef enum logic [2:0] {
    src_data_in, src_reg_a, src_reg_x, src_reg_y, src_alu_result
  } data_src_e;

  // low and high address bytes always come from the same place
  typedef enum logic {addr_pc, addr_reg} addr_src_e;

  typedef struct packed {
    logic load_inst_reg;
    logic inc_pc;
    logic load_pc;
    logic load_addr_low;
    logic load_addr_high;
    logic load_input_a;
    logic load_input_b;
    logic reset_input_a;
    logic load_a;
    logic load_x;
    logic load_y;
    logic update_n;
    logic update_z;
    logic update_c;
    logic update_v;
    logic clear_c;
    logic set_c;
    logic write;            // 1 write, 0 read
  } ctrl_word_t;

  localparam logic [`OPCODE_WIDTH-1:0] opc_lda_imm = 8'hA9;
  localparam logic [`OPCODE_WIDTH-1:0] opc_lda_abs = 8'hAD;
  localparam logic [`OPCODE_WIDTH-1:0] opc_ldx_imm = 8'hA2;
  localparam logic [`OPCODE_WIDTH-1:0] opc_ldx_abs = 8'hAE;
  localparam logic [`OPCODE_WIDTH-1:0] opc_ldy_imm = 8'hA0;
  localparam logic [`OPCODE_WIDTH-1:0] opc_ldy_abs = 8'hAC;
  localparam logic [`OPCODE_WIDTH-1:0] opc_sta_abs = 8'h8D;
  localparam logic [`OPCODE_WIDTH-1:0] opc_stx_abs = 8'h8E;
  localparam logic [`OPCODE_WIDTH-1:0] opc_sty_abs = 8'h8C;
  localparam logic [`OPCODE_WIDTH-1:0] opc_adc_imm = 8'h69;
  localparam logic [`OPCODE_WIDTH-1:0] opc_adc_abs = 8'h6D;
  localparam logic [`OPCODE_WIDTH-1:0] opc_sbc_imm = 8'hE9;
  localparam logic [`OPCODE_WIDTH-1:0] opc_sbc_abs = 8'hED;
  localparam logic [`OPCODE_WIDTH-1:0] opc_and_imm = 8'h29;
  localparam logic [`OPCODE_WIDTH-1:0] opc_and_abs = 8'h2D;
  localparam logic [`OPCODE_WIDTH-1:0] opc_ora_imm = 8'h09;
  localparam logic [`OPCODE_WIDTH-1:0] opc_ora_abs = 8'h0D;
  localparam logic [`OPCODE_WIDTH-1:0] opc_eor_imm = 8'h49;
  localparam logic [`OPCODE_WIDTH-1:0] opc_eor_abs = 8'h4D;
  localparam logic [`OPCODE_WIDTH-1:0] opc_cmp_imm = 8'hC9;
  localparam logic [`OPCODE_WIDTH-1:0] opc_cmp_abs = 8'hCD;
  localparam logic [`OPCODE_WIDTH-1:0] opc_inx_impl = 8'hE8;
  localparam logic [`OPCODE_WIDTH-1:0] opc_clc_impl = 8'h18;
  localparam logic [`OPCODE_WIDTH-1:0] opc_sec_impl = 8'h38;
  localparam logic [`OPCODE_WIDTH-1:0] opc_nop_impl = 8'hEA;
  localparam logic [`OPCODE_WIDTH-1:0] opc_jmp_abs = 8'h4C;
  // branches take an absolute target here
  localparam logic [`OPCODE_WIDTH-1:0] opc_bpl_abs = 8'h10;
  localparam logic [`OPCODE_WIDTH-1:0] opc_bmi_abs = 8'h30;
  localparam logic [`OPCODE_WIDTH-1:0] opc_bvc_abs = 8'h50;
  localparam logic [`OPCODE_WIDTH-1:0] opc_bvs_abs = 8'h70;
  localparam logic [`OPCODE_WIDTH-1:0] opc_bcc_abs = 8'h90;
  localparam logic [`OPCODE_WIDTH-1:0] opc_bcs_abs = 8'hB0;
  localparam logic [`OPCODE_WIDTH-1:0] opc_bne_abs = 8'hD0;
  localparam logic [`OPCODE_WIDTH-1:0] opc_beq_abs = 8'hF0;

endpackage

// File: rtl/instr_sequencer.sv
`include "cu_macros.svh"

module instr_sequencer (
  input  logic                    clk,
  input  logic                    reset,
  input  cu_pkg::op_class_e       op_class,
  input  cu_pkg::addr_mode_e      addr_mode,
  input  logic                    valid,
  output cu_pkg::seq_state_e      state,
  output logic [`STEP_WIDTH-1:0]  step
);

  cu_pkg::seq_state_e      next_state;
  logic [`STEP_WIDTH-1:0]  next_step;

  // index of the final execute step for each class
  function automatic logic [`STEP_WIDTH-1:0] last_step(cu_pkg::op_class_e cls);
    case (cls)
      cu_pkg::cls_inx: return `STEP_WIDTH'(1);
      cu_pkg::cls_arith, cu_pkg::cls_logic, cu_pkg::cls_compare: return `STEP_WIDTH'(2);
      default: return '0;
    endcase
  endfunction

  always_comb begin
    next_state = state;
    next_step  = '0;
    case (state)
      cu_pkg::st_fetch: next_state = cu_pkg::st_decode;
      cu_pkg::st_decode: begin
        if (!valid) begin
          next_state = cu_pkg::st_halted;
        end else if (op_class == cu_pkg::cls_nop) begin
          next_state = cu_pkg::st_fetch;    // nop is done after decode
        end else if (addr_mode == cu_pkg::mode_abs) begin
          next_state = cu_pkg::st_mem1;
        end else begin
          next_state = cu_pkg::st_exec;
        end
      end
      cu_pkg::st_mem1: next_state = cu_pkg::st_exec;
      cu_pkg::st_exec: begin
        if (step == last_step(op_class)) begin
          next_state = cu_pkg::st_fetch;
        end else begin
          next_step = step + 1'b1;
        end
      end
      cu_pkg::st_halted: next_state = cu_pkg::st_halted;    // sticky until reset
      default: next_state = cu_pkg::st_halted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cu_pkg::st_fetch;
      step  <= '0;
    end else begin
      state <= next_state;
      step  <= next_step;
    end
  end

endmodule

// File: rtl/opcode_decoder.sv
`include "cu_macros.svh"

module opcode_decoder (
  input  logic [`OPCODE_WIDTH-1:0] opcode,
  output cu_pkg::op_class_e        op_class,
  output cu_pkg::addr_mode_e       addr_mode,
  output cu_pkg::alu_op_e          alu_op,
  output cu_pkg::reg_e             reg_sel,
  output logic                     valid
);

  always_comb begin
    op_class = cu_pkg::cls_nop;
    alu_op   = cu_pkg::alu_add;
    reg_sel  = cu_pkg::sel_a;
    valid    = 1'b1;
    case (opcode)
      cu_pkg::opc_lda_imm, cu_pkg::opc_lda_abs: op_class = cu_pkg::cls_load;
      cu_pkg::opc_ldx_imm, cu_pkg::opc_ldx_abs: begin
        op_class = cu_pkg::cls_load;
        reg_sel  = cu_pkg::sel_x;
      end
      cu_pkg::opc_ldy_imm, cu_pkg::opc_ldy_abs: begin
        op_class = cu_pkg::cls_load;
        reg_sel  = cu_pkg::sel_y;
      end
      cu_pkg::opc_sta_abs: op_class = cu_pkg::cls_store;
      cu_pkg::opc_stx_abs: begin
        op_class = cu_pkg::cls_store;
        reg_sel  = cu_pkg::sel_x;
      end
      cu_pkg::opc_sty_abs: begin
        op_class = cu_pkg::cls_store;
        reg_sel  = cu_pkg::sel_y;
      end
      cu_pkg::opc_adc_imm, cu_pkg::opc_adc_abs: op_class = cu_pkg::cls_arith;
      cu_pkg::opc_sbc_imm, cu_pkg::opc_sbc_abs: begin
        op_class = cu_pkg::cls_arith;
        alu_op   = cu_pkg::alu_sub;
      end
      cu_pkg::opc_and_imm, cu_pkg::opc_and_abs: begin
        op_class = cu_pkg::cls_logic;
        alu_op   = cu_pkg::alu_and;
      end
      cu_pkg::opc_ora_imm, cu_pkg::opc_ora_abs: begin
        op_class = cu_pkg::cls_logic;
        alu_op   = cu_pkg::alu_or;
      end
      cu_pkg::opc_eor_imm, cu_pkg::opc_eor_abs: begin
        op_class = cu_pkg::cls_logic;
        alu_op   = cu_pkg::alu_xor;
      end
      cu_pkg::opc_cmp_imm, cu_pkg::opc_cmp_abs: begin
        op_class = cu_pkg::cls_compare;    // compare is a subtract with no writeback
        alu_op   = cu_pkg::alu_sub;
      end
      cu_pkg::opc_inx_impl: begin
        op_class = cu_pkg::cls_inx;
        reg_sel  = cu_pkg::sel_x;
      end
      cu_pkg::opc_clc_impl: op_class = cu_pkg::cls_clc;
      cu_pkg::opc_sec_impl: op_class = cu_pkg::cls_sec;
      cu_pkg::opc_nop_impl: op_class = cu_pkg::cls_nop;
      cu_pkg::opc_jmp_abs:  op_class = cu_pkg::cls_jmp;
      cu_pkg::opc_bpl_abs, cu_pkg::opc_bmi_abs, cu_pkg::opc_bvc_abs, cu_pkg::opc_bvs_abs,
      cu_pkg::opc_bcc_abs, cu_pkg::opc_bcs_abs, cu_pkg::opc_bne_abs, cu_pkg::opc_beq_abs:
        op_class = cu_pkg::cls_branch;
      default: valid = 1'b0;
    endcase
  end

  // anything not listed, undecoded opcodes included, is implied
  always_comb begin
    case (opcode)
      cu_pkg::opc_lda_imm, cu_pkg::opc_ldx_imm, cu_pkg::opc_ldy_imm,
      cu_pkg::opc_adc_imm, cu_pkg::opc_sbc_imm, cu_pkg::opc_and_imm,
      cu_pkg::opc_ora_imm, cu_pkg::opc_eor_imm, cu_pkg::opc_cmp_imm:
        addr_mode = cu_pkg::mode_imm;
      cu_pkg::opc_lda_abs, cu_pkg::opc_ldx_abs, cu_pkg::opc_ldy_abs,
      cu_pkg::opc_sta_abs, cu_pkg::opc_stx_abs, cu_pkg::opc_sty_abs,
      cu_pkg::opc_adc_abs, cu_pkg::opc_sbc_abs, cu_pkg::opc_and_abs,
      cu_pkg::opc_ora_abs, cu_pkg::opc_eor_abs, cu_pkg::opc_cmp_abs,
      cu_pkg::opc_jmp_abs,
      cu_pkg::opc_bpl_abs, cu_pkg::opc_bmi_abs, cu_pkg::opc_bvc_abs, cu_pkg::opc_bvs_abs,
      cu_pkg::opc_bcc_abs, cu_pkg::opc_bcs_abs, cu_pkg::opc_bne_abs, cu_pkg::opc_beq_abs:
        addr_mode = cu_pkg::mode_abs;
      default: addr_mode = cu_pkg::mode_impl;
    endcase
  end

endmodule

// File: tests/control_unit_checker.sv
module control_unit_checker (
  input logic               clk,
  input logic               reset,
  input cu_pkg::ctrl_word_t ctrl,
  input cu_pkg::seq_state_e state,
  input logic               halted
);

  int unsigned assert_fails = 0;

  no_write_in_fetch: assert property (@(posedge clk) disable iff (reset)
    !(ctrl.write && ctrl.load_inst_reg))
    else begin
      $error("write and instruction load asserted in the same cycle");
      assert_fails++;
    end

  // only reset leaves the halted state
  halt_is_sticky: assert property (@(posedge clk) (halted && !reset) |=> halted)
    else begin
      $error("halted dropped without a reset");
      assert_fails++;
    end

  pc_load_in_exec: assert property (@(posedge clk) disable iff (reset)
    ctrl.load_pc |-> (state != cu_pkg::st_fetch && state != cu_pkg::st_decode))
    else begin
      $error("load_pc asserted during fetch or decode");
      assert_fails++;
    end

  fetch_after_reset: assert property (@(posedge clk) $fell(reset) |-> ctrl.load_inst_reg)
    else begin
      $error("first cycle after reset is not a fetch");
      assert_fails++;
    end

endmodule

bind control_unit control_unit_checker checker0 (
  .clk    (clk),
  .reset  (reset),
  .ctrl   (ctrl),
  .state  (state),
  .halted (halted)
);

// File: tests/control_unit_tb.sv
`include "cu_macros.svh"

module control_unit_tb;

  localparam int PERIOD = 8;

  logic                     clk;
  logic                     reset;
  logic [`OPCODE_WIDTH-1:0] opcode;
  logic [`FLAG_COUNT-1:0]   flags;
  cu_pkg::ctrl_word_t       ctrl;
  cu_pkg::alu_op_e          alu_op;
  cu_pkg::data_src_e        data_src;
  cu_pkg::addr_src_e        addr_src;
  logic                     halted;

  // main program ends on an undecoded opcode, the short tail runs after the second reset
  logic [7:0] prog [$] = '{
    8'hA9, 8'hAD, 8'hA2, 8'hAE, 8'hA0, 8'hAC, 8'h8D, 8'h8E, 8'h8C,
    8'h69, 8'h6D, 8'hE9, 8'hED, 8'h29, 8'h2D, 8'h09, 8'h0D, 8'h49, 8'h4D, 8'hC9, 8'hCD,
    8'hE8, 8'h18, 8'h38, 8'hEA, 8'h4C,
    8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0,
    8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0,
    8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0,
    8'h02,
    8'hA9, 8'hE8, 8'hFF
  };

  int pidx;
  int reset_left;
  int cyc;            // cycle within the current instruction, 0 is fetch
  int gap;
  int last_len;
  int len;
  int checks;
  int errors;
  cu_pkg::ctrl_word_t e_ctrl;
  cu_pkg::alu_op_e    e_alu;
  cu_pkg::data_src_e  e_src;
  cu_pkg::addr_src_e  e_addr;
  logic               e_halted;

  control_unit dut0 (
    .clk      (clk),
    .reset    (reset),
    .opcode   (opcode),
    .flags    (flags),
    .ctrl     (ctrl),
    .alu_op   (alu_op),
    .data_src (data_src),
    .addr_src (addr_src),
    .halted   (halted)
  );

  // 6502 encoding rules for the kept subset, ok low for anything else
  function automatic void classify(input logic [7:0] op, output cu_pkg::op_class_e kind,
                                   output int mem, output logic imm,
                                   output cu_pkg::alu_op_e alu, output int rsel,
                                   output logic ok);
    kind = cu_pkg::cls_nop;
    alu  = cu_pkg::alu_add;
    mem  = 0;
    imm  = 1'b0;
    ok   = 1'b1;
    rsel = op[1] ? 1 : (op[0] ? 0 : 2);    // 0 a, 1 x, 2 y
    if (op[4:0] == 5'b10000) begin
      kind = cu_pkg::cls_branch;
      mem  = 1;
    end else if (op[4:3] == 2'b01 && op[1:0] == 2'b01 && op[7:5] != 3'd4 && op[7:5] != 3'd5) begin
      mem = op[2] ? 1 : 0;                 // bbb 010 immediate, 011 absolute
      imm = ~op[2];
      case (op[7:5])
        3'd0:    alu = cu_pkg::alu_or;
        3'd1:    alu = cu_pkg::alu_and;
        3'd2:    alu = cu_pkg::alu_xor;
        3'd3:    alu = cu_pkg::alu_add;
        default: alu = cu_pkg::alu_sub;
      endcase
      if (op[7:5] == 3'd6) begin
        kind = cu_pkg::cls_compare;
      end else if (op[7:5] == 3'd3 || op[7:5] == 3'd7) begin
        kind = cu_pkg::cls_arith;
      end else begin
        kind = cu_pkg::cls_logic;
      end
    end else begin
      case (op)
        cu_pkg::opc_lda_imm, cu_pkg::opc_ldx_imm, cu_pkg::opc_ldy_imm: begin
          kind = cu_pkg::cls_load;
          imm  = 1'b1;
        end
        cu_pkg::opc_lda_abs, cu_pkg::opc_ldx_abs, cu_pkg::opc_ldy_abs: begin
          kind = cu_pkg::cls_load;
          mem  = 1;
        end
        cu_pkg::opc_sta_abs, cu_pkg::opc_stx_abs, cu_pkg::opc_sty_abs: begin
          kind = cu_pkg::cls_store;
          mem  = 1;
        end
        cu_pkg::opc_jmp_abs: begin
          kind = cu_pkg::cls_jmp;
          mem  = 1;
        end
        cu_pkg::opc_inx_impl: kind = cu_pkg::cls_inx;
        cu_pkg::opc_clc_impl: kind = cu_pkg::cls_clc;
        cu_pkg::opc_sec_impl: kind = cu_pkg::cls_sec;
        cu_pkg::opc_nop_impl: kind = cu_pkg::cls_nop;
        default: ok = 1'b0;
      endcase
    end
  endfunction

  // 2 + m + e cycles, 0 when the opcode never completes
  function automatic int instr_len(input logic [7:0] op);
    cu_pkg::op_class_e kind;
    cu_pkg::alu_op_e   alu;
    int                mem;
    int                rsel;
    logic              imm;
    logic              ok;
    classify(op, kind, mem, imm, alu, rsel, ok);
    if (!ok) return 0;
    case (kind)
      cu_pkg::cls_nop: return 2;
      cu_pkg::cls_inx: return 4 + mem;
      cu_pkg::cls_arith, cu_pkg::cls_logic, cu_pkg::cls_compare: return 5 + mem;
      default: return 3 + mem;
    endcase
  endfunction

  function automatic void expected_outputs(input logic [7:0] op, input logic [3:0] fl,
                                           input int c, output cu_pkg::ctrl_word_t w,
                                           output cu_pkg::alu_op_e a,
                                           output cu_pkg::data_src_e d,
                                           output cu_pkg::addr_src_e s, output logic h);
    cu_pkg::op_class_e kind;
    cu_pkg::alu_op_e   alu;
    int                mem;
    int                rsel;
    int                k;
    logic              imm;
    logic              ok;
    w = '0;
    a = cu_pkg::alu_add;
    d = cu_pkg::src_data_in;
    s = cu_pkg::addr_pc;
    h = 1'b0;
    classify(op, kind, mem, imm, alu, rsel, ok);
    k = c - 2 - mem;
    if (c == 0) begin
      w.load_inst_reg = 1'b1;
      w.inc_pc        = 1'b1;
    end else if (!ok) begin
      h = (c >= 2);
    end else if (c == 1 || (c == 2 && mem == 1)) begin
      w.inc_pc         = (mem == 1);       // operand address bytes
      w.load_addr_low  = (mem == 1 && c == 1);
      w.load_addr_high = (c == 2);
    end else begin
      if (mem == 1) s = cu_pkg::addr_reg;
      w.inc_pc = imm && (k == 0);
      case (kind)
        cu_pkg::cls_arith, cu_pkg::cls_logic, cu_pkg::cls_compare: begin
          a = alu;
          if (k == 0) begin
            w.load_input_b = 1'b1;
          end else if (k == 1) begin
            d              = cu_pkg::src_reg_a;
            w.load_input_a = 1'b1;
          end else begin
            d          = cu_pkg::src_alu_result;
            w.load_a   = (kind != cu_pkg::cls_compare);
            w.update_n = 1'b1;
            w.update_z = 1'b1;
            w.update_c = (kind == cu_pkg::cls_arith || kind == cu_pkg::cls_compare);
            w.update_v = (kind == cu_pkg::cls_arith);
          end
        end
        cu_pkg::cls_load: begin
          w.load_a   = (rsel == 0);
          w.load_x   = (rsel == 1);
          w.load_y   = (rsel == 2);
          w.update_n = 1'b1;
          w.update_z = 1'b1;
        end
        cu_pkg::cls_store: begin
          w.write = 1'b1;
          if (rsel == 1) d = cu_pkg::src_reg_x;
          else if (rsel == 2) d = cu_pkg::src_reg_y;
          else d = cu_pkg::src_reg_a;
        end
        cu_pkg::cls_inx: begin
          d = (k == 0) ? cu_pkg::src_reg_x : cu_pkg::src_alu_result;
          w.load_input_b  = (k == 0);
          w.reset_input_a = (k == 0);     // x + 1 through the adder
          w.load_x        = (k == 1);
          w.update_n      = (k == 1);
          w.update_z      = (k == 1);
        end
        cu_pkg::cls_jmp: w.load_pc = 1'b1;
        cu_pkg::cls_branch: begin
          // flags are N V C Z at index 0 to 3
          case (op)
            cu_pkg::opc_bpl_abs: w.load_pc = !fl[0];
            cu_pkg::opc_bmi_abs: w.load_pc = fl[0];
            cu_pkg::opc_bvc_abs: w.load_pc = !fl[1];
            cu_pkg::opc_bvs_abs: w.load_pc = fl[1];
            cu_pkg::opc_bcc_abs: w.load_pc = !fl[2];
            cu_pkg::opc_bcs_abs: w.load_pc = fl[2];
            cu_pkg::opc_bne_abs: w.load_pc = !fl[3];
            default:             w.load_pc = fl[3];
          endcase
        end
        cu_pkg::cls_clc:    w.clear_c = 1'b1;
        cu_pkg::cls_sec:    w.set_c   = 1'b1;
        default: ;
      endcase
    end
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("Fail at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
    errors = errors + 1;
  endtask

  task automatic wait_for_halt();
    do @(negedge clk); while (halted !== 1'b1);
  endtask

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset, flags and the instruction register all change on the falling edge
  always @(negedge clk) begin
    flags = `FLAG_COUNT'($urandom);
    if (reset_left > 0) begin
      reset      = 1'b1;
      reset_left = reset_left - 1;
    end else begin
      reset = 1'b0;
      if (ctrl.load_inst_reg === 1'b1 && pidx < prog.size()) begin
        opcode = prog[pidx];
        pidx   = pidx + 1;
      end
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      cyc      = 0;
      gap      = 0;
      last_len = 0;
    end else begin
      expected_outputs(opcode, flags, cyc, e_ctrl, e_alu, e_src, e_addr, e_halted);
      checks = checks + 1;
      if (ctrl !== e_ctrl) report_mismatch("ctrl", 32'(ctrl), 32'(e_ctrl));
      if (alu_op !== e_alu) report_mismatch("alu_op", 32'(alu_op), 32'(e_alu));
      if (data_src !== e_src) report_mismatch("data_src", 32'(data_src), 32'(e_src));
      if (addr_src !== e_addr) report_mismatch("addr_src", 32'(addr_src), 32'(e_addr));
      if (halted !== e_halted) report_mismatch("halted", 32'(halted), 32'(e_halted));
      if (ctrl.load_inst_reg === 1'b1) begin
        if (last_len != 0 && gap != last_len) begin
          report_mismatch("instruction length", 32'(gap), 32'(last_len));
        end
        gap = 0;
      end
      gap = gap + 1;
      if (cyc == 1) last_len = instr_len(opcode);
      len = instr_len(opcode);
      if (cyc + 1 == len) cyc = 0;
      else if (len != 0 || cyc < 2) cyc = cyc + 1;
    end
  end

  // at most 6 cycles per instruction, 8 per entry leaves room for reset and halts
  initial begin
    #(prog.size() * 8 * PERIOD + 50 * PERIOD);
    $display("Timeout: the program did not reach its end in time");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    void'($urandom(28208));
    reset      = 1'b1;
    opcode     = cu_pkg::opc_nop_impl;
    flags      = '0;
    reset_left = 3;    // high from time 0, so four rising edges see it
    pidx       = 0;
    checks     = 0;
    errors     = 0;
    wait_for_halt();
    repeat (6) @(posedge clk);    // halted has to hold
    reset_left = 4;
    repeat (6) @(posedge clk);
    wait_for_halt();
    repeat (3) @(negedge clk);
    $display("cycles checked %0d, mismatches %0d, assertion failures %0d",
             checks, errors, dut0.checker0.assert_fails);
    if (errors == 0 && dut0.checker0.assert_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+rtl
rtl/cu_pkg.sv
rtl/opcode_decoder.sv
rtl/instr_sequencer.sv
rtl/control_encoder.sv
rtl/control_unit.sv
tests/control_unit_checker.sv
tests/control_unit_tb.sv
